//--- hw/arcade_pkg.sv
// Shared types for the arcade frame; field order of the packed structs is fixed, MSB first
`default_nettype none

package arcade_pkg;

    // Menu status word as delivered by the OSD controller
    typedef logic [31:0] status_t;

    // Game pixel, 3-3-2 with red in the top bits
    typedef logic [7:0] rgb332_t;

    // One VGA colour channel on the board DAC
    typedef logic [5:0] vga_chan_t;

    // Difficulty code as the game expects it
    typedef logic [1:0] level_t;

    // Lives setting, straight from the menu
    typedef logic [1:0] lives_t;

    // Difficulty encodings seen by the game
    localparam level_t LEVEL_EASY   = 2'b00;
    localparam level_t LEVEL_NORMAL = 2'b01;
    localparam level_t LEVEL_HARD   = 2'b10;
    localparam level_t LEVEL_VHARD  = 2'b11;

    // DIP switch bundle handed to the game core
    typedef struct packed {
        logic   pause_n;    // Low pauses the game
        level_t level;
        lives_t lives;
        logic   mixing;     // Screen filter enable
        logic   upright;    // Cabinet type, always upright
    } dip_cfg_t;

    // Raster strobes at the base 15 kHz rate
    typedef struct packed {
        logic hb;
        logic vb;
        logic hs;
        logic vs;
    } raster_t;

endpackage

`default_nettype wire

//--- hw/dip_mapper.sv
// Status bit map follows the OSD menu: 1 pause, 3:2 level, 6:5 lives, 9 filter off, 15 reset
`timescale 1ns/1ps
`default_nettype none

module dip_mapper
    import arcade_pkg::*;
(
    input  wire logic     clk_sys,
    input  wire logic     reset,
    input  wire status_t  status,
    input  wire logic     game_pause,
    input  wire logic [1:0] coin,
    output dip_cfg_t      cfg,
    output logic          coin_any,
    output logic          game_reset
);

    level_t   level_nxt;
    dip_cfg_t cfg_nxt;

    // Menu order is Normal, Easy, Hard, Very hard
    always_comb begin
        case (status[3:2])
            2'b00:   level_nxt = LEVEL_NORMAL;
            2'b01:   level_nxt = LEVEL_EASY;
            2'b10:   level_nxt = LEVEL_HARD;
            default: level_nxt = LEVEL_VHARD;
        endcase
    end

    always_comb begin
        cfg_nxt.pause_n = ~status[1] & ~game_pause;    // Menu or button pause
        cfg_nxt.level   = level_nxt;
        cfg_nxt.lives   = status[6:5];
        cfg_nxt.mixing  = ~status[9];                  // Menu bit set turns filter off
        cfg_nxt.upright = 1'b1;
    end

    // Latch everything the game sees
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            cfg.pause_n <= 1'b1;
            cfg.level   <= LEVEL_NORMAL;
            cfg.lives   <= '0;
            cfg.mixing  <= 1'b1;
            cfg.upright <= 1'b1;
            coin_any    <= 1'b0;
            game_reset  <= 1'b1;    // Game stays held while the frame resets
        end else begin
            cfg         <= cfg_nxt;
            coin_any    <= |coin;
            game_reset  <= status[15];
        end
    end

endmodule

`default_nettype wire

//--- hw/video_timing.sv
// Needs PXL2_DIV >= 2, HLEN >= 3 and VLEN >= 2; raster fields are decoded from the next count
`timescale 1ns/1ps
`default_nettype none

module video_timing
    import arcade_pkg::*;
#(
    parameter int HLEN     = 16,
    parameter int HACTIVE  = 12,
    parameter int VLEN     = 10,
    parameter int VACTIVE  = 8,
    parameter int PXL2_DIV = 4
) (
    input  wire logic clk_sys,
    input  wire logic reset,
    output logic      pxl_cen,
    output logic      pxl2_cen,
    output raster_t   raster
);

    localparam int DW = $clog2(PXL2_DIV);
    localparam int HW = $clog2(HLEN);
    localparam int VW = $clog2(VLEN);

    logic [DW-1:0] div_cnt;
    logic          div_wrap;
    logic          half;        // Selects which pxl2 pulse also carries pxl_cen
    logic [HW-1:0] hcnt;
    logic [HW-1:0] h_next;
    logic [VW-1:0] vcnt;
    logic [VW-1:0] v_next;
    logic          h_last;
    logic          v_last;
    raster_t       raster_nxt;

    assign div_wrap = div_cnt == DW'(PXL2_DIV - 1);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            div_cnt  <= '0;
            half     <= 1'b0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            div_cnt  <= div_wrap ? '0 : div_cnt + 1'b1;
            half     <= half ^ div_wrap;
            pxl2_cen <= div_wrap;
            pxl_cen  <= div_wrap & ~half;
        end
    end

    assign h_last = hcnt == HW'(HLEN - 1);
    assign v_last = vcnt == VW'(VLEN - 1);
    assign h_next = h_last ? '0 : hcnt + 1'b1;

    always_comb begin
        v_next = vcnt;
        if (h_last) begin
            v_next = v_last ? '0 : vcnt + 1'b1;    // New line at end of row
        end
    end

    always_comb begin
        raster_nxt.hb = h_next >= HW'(HACTIVE);
        raster_nxt.hs = h_next >= HW'(HLEN - 2);   // Last two pixels of the line
        raster_nxt.vb = v_next >= VW'(VACTIVE);
        raster_nxt.vs = v_next == VW'(VLEN - 1);   // Last line of the frame
    end

    // Counters and strobes move together on the base pixel enable
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            hcnt   <= '0;
            vcnt   <= '0;
            raster <= '0;
        end else if (pxl_cen) begin
            hcnt   <= h_next;
            vcnt   <= v_next;
            raster <= raster_nxt;
        end
    end

endmodule

`default_nettype wire

//--- hw/scan_doubler.sv
// One line of latency; assumes hs rises away from pxl2_cen and lines are at most HLEN pixels
`timescale 1ns/1ps
`default_nettype none

module scan_doubler
    import arcade_pkg::*;
#(
    parameter int HLEN = 16
) (
    input  wire logic    clk_sys,
    input  wire logic    reset,
    input  wire logic    pxl_cen,
    input  wire logic    pxl2_cen,
    input  wire logic    hs,
    input  wire rgb332_t pixel,
    output rgb332_t      x2_pixel,
    output logic         x2_hs
);

    localparam int CW = $clog2(HLEN);

    typedef logic [CW-1:0] col_t;

    rgb332_t         line_mem [2][HLEN];
    logic [HLEN-1:0] line_vld [2];    // Entry written since reset
    logic            hs_d;
    logic            hs_rise;
    logic            wbank;
    logic            rbank;
    col_t            wcnt;
    col_t            rcnt;
    logic            w_last;
    logic            r_last;
    rgb332_t         rd_data;

    assign hs_rise = hs & ~hs_d;
    assign rbank   = ~wbank;           // Read the line finished last
    assign w_last  = wcnt == CW'(HLEN - 1);
    assign r_last  = rcnt == CW'(HLEN - 1);

    // Unwritten entries show black
    assign rd_data = line_vld[rbank][rcnt] ? line_mem[rbank][rcnt] : '0;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            hs_d        <= 1'b0;
            wbank       <= 1'b0;
            wcnt        <= '0;
            rcnt        <= '0;
            x2_hs       <= 1'b0;
            line_vld[0] <= '0;
            line_vld[1] <= '0;
        end else begin
            hs_d <= hs;
            if (pxl_cen) begin
                line_vld[wbank][wcnt] <= 1'b1;
            end
            if (hs_rise) begin
                wbank <= ~wbank;    // Swap banks at each new line
                wcnt  <= '0;
                rcnt  <= '0;
            end else begin
                if (pxl_cen) begin
                    wcnt <= w_last ? '0 : wcnt + 1'b1;
                end
                if (pxl2_cen) begin
                    rcnt <= r_last ? '0 : rcnt + 1'b1;    // Wraps twice per input line
                end
            end
            if (pxl2_cen) begin
                x2_hs <= rcnt >= CW'(HLEN - 2);           // Aligned with x2_pixel
            end
        end
    end

    // Line storage and output pixel
    always_ff @(posedge clk_sys) begin
        if (pxl_cen) begin
            line_mem[wbank][wcnt] <= pixel;
        end
        if (pxl2_cen) begin
            x2_pixel <= rd_data;
        end
    end

endmodule

`default_nettype wire

//--- hw/arcade_frame.sv
// Game core sits outside; pixel must be valid on pxl_cen and VGA colours are 6 bits per channel
`timescale 1ns/1ps
`default_nettype none

module arcade_frame
    import arcade_pkg::*;
#(
    parameter int HLEN     = 16,
    parameter int HACTIVE  = 12,
    parameter int VLEN     = 10,
    parameter int VACTIVE  = 8,
    parameter int PXL2_DIV = 4
) (
    input  wire logic       clk_sys,
    input  wire logic       reset,
    input  wire status_t    status,
    input  wire logic       game_pause,
    input  wire logic [1:0] coin,
    input  wire rgb332_t    pixel,
    output dip_cfg_t        cfg,
    output logic            coin_any,
    output logic            game_reset,
    output logic            pxl_cen,
    output logic            pxl2_cen,
    output raster_t         raster,
    output vga_chan_t       vga_r,
    output vga_chan_t       vga_g,
    output vga_chan_t       vga_b,
    output logic            vga_hs,
    output logic            vga_vs
);

    rgb332_t x2_pixel;
    logic    x2_hs;

    dip_mapper i_dip_mapper (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .status     (status),
        .game_pause (game_pause),
        .coin       (coin),
        .cfg        (cfg),
        .coin_any   (coin_any),
        .game_reset (game_reset)
    );

    video_timing #(
        .HLEN     (HLEN),
        .HACTIVE  (HACTIVE),
        .VLEN     (VLEN),
        .VACTIVE  (VACTIVE),
        .PXL2_DIV (PXL2_DIV)
    ) i_video_timing (
        .clk_sys  (clk_sys),
        .reset    (reset),
        .pxl_cen  (pxl_cen),
        .pxl2_cen (pxl2_cen),
        .raster   (raster)
    );

    scan_doubler #(
        .HLEN (HLEN)
    ) i_scan_doubler (
        .clk_sys  (clk_sys),
        .reset    (reset),
        .pxl_cen  (pxl_cen),
        .pxl2_cen (pxl2_cen),
        .hs       (raster.hs),
        .pixel    (pixel),
        .x2_pixel (x2_pixel),
        .x2_hs    (x2_hs)
    );

    // Widen 3-3-2 to 6-6-6 by repeating bits so full scale stays full scale
    assign vga_r  = {x2_pixel[7:5], x2_pixel[7:5]};
    assign vga_g  = {x2_pixel[4:2], x2_pixel[4:2]};
    assign vga_b  = {3{x2_pixel[1:0]}};
    assign vga_hs = x2_hs;
    assign vga_vs = raster.vs;    // Frame timing is shared with the 15 kHz side

endmodule

`default_nettype wire

//--- tests/arcade_frame_properties.sv
// Covers enable nesting, sync inside blanking and raster update timing; no pixel data checks
`timescale 1ns/1ps
`default_nettype none

module arcade_frame_properties
    import arcade_pkg::*;
(
    input wire logic    clk_sys,
    input wire logic    reset,
    input wire logic    pxl_cen,
    input wire logic    pxl2_cen,
    input wire raster_t raster,
    input wire logic    coin_any
);

    // Base enable always rides on a double-rate pulse
    a_cen_nested: assert property (@(posedge clk_sys) disable iff (reset) pxl_cen |-> pxl2_cen)
        else $error("pxl_cen high without pxl2_cen");

    a_hs_in_hb: assert property (@(posedge clk_sys) disable iff (reset) raster.hs |-> raster.hb)
        else $error("horizontal sync outside blanking");

    a_raster_on_cen: assert property (@(posedge clk_sys) disable iff (reset)
        (raster != $past(raster)) |-> $past(pxl_cen))
        else $error("raster changed without a preceding pxl_cen");

    a_coin_reset: assert property (@(posedge clk_sys) reset |=> !coin_any)
        else $error("coin_any high in the cycle after reset");

endmodule

bind arcade_frame arcade_frame_properties i_arcade_frame_properties (
    .clk_sys  (clk_sys),
    .reset    (reset),
    .pxl_cen  (pxl_cen),
    .pxl2_cen (pxl2_cen),
    .raster   (raster),
    .coin_any (coin_any)
);

`default_nettype wire

//--- tests/tb_arcade_frame.sv
// Random run over three frames at the default 16x10 raster; pixel data checked from the first line
`timescale 1ns/1ps
`default_nettype none

module tb_arcade_frame
    import arcade_pkg::*;
();

    localparam int HLEN     = 16;
    localparam int HACTIVE  = 12;
    localparam int VLEN     = 10;
    localparam int VACTIVE  = 8;
    localparam int PXL2_DIV = 4;
    localparam int FRAMES   = 3;
    localparam int TIMEOUT  = 5000;    // Cycles allowed for all frames

    logic      clk_sys;
    logic      reset;
    status_t   status;
    logic      game_pause;
    logic [1:0] coin;
    rgb332_t   pixel;
    dip_cfg_t  cfg;
    logic      coin_any;
    logic      game_reset;
    logic      pxl_cen;
    logic      pxl2_cen;
    raster_t   raster;
    vga_chan_t vga_r;
    vga_chan_t vga_g;
    vga_chan_t vga_b;
    logic      vga_hs;
    logic      vga_vs;

    logic [31:0] lfsr;
    int          value_errors;
    int          timeout_errors;
    rgb332_t     line_m [2][HLEN];    // Last two input lines
    logic        line_v [2][HLEN];
    logic        wbank_m;
    logic        hs_prev;
    logic        vs_prev;
    logic        phase_m;             // Next pxl2_cen also carries pxl_cen
    logic        x2_pending;
    logic        exp_hs;
    rgb332_t     exp_px;
    int          widx;
    int          ridx;
    int          hpos;
    int          vpos;
    int          gap;
    int          cyc;
    int          frames;

    arcade_frame i_arcade_frame (.*);

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic dip_cfg_t dip_rule(input status_t s, input logic pause);
        dip_cfg_t c;
        case (s[3:2])
            2'b00:   c.level = 2'b01;
            2'b01:   c.level = 2'b00;
            default: c.level = s[3:2];
        endcase
        c.pause_n = !s[1] && !pause;
        c.lives   = s[6:5];
        c.mixing  = !s[9];
        c.upright = 1'b1;
        return c;
    endfunction

    function automatic vga_chan_t widen_3b(input logic [2:0] v);
        return {v, v};
    endfunction

    function automatic vga_chan_t widen_2b(input logic [1:0] v);
        return {v, v, v};
    endfunction

    task automatic check_cfg(input string name, input dip_cfg_t exp, input dip_cfg_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h at %0t", name, exp, act, $time);
            value_errors++;
        end
    endtask

    task automatic check_pixel(input string name, input rgb332_t exp, input rgb332_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h at %0t", name, exp, act, $time);
            value_errors++;
        end
    endtask

    task automatic check_chan(input string name, input vga_chan_t exp, input vga_chan_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h at %0t", name, exp, act, $time);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s expected %b actual %b at %0t", name, exp, act, $time);
            value_errors++;
        end
    endtask

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    initial begin
        logic [31:0] r;
        reset = 1'b1;
        status = 32'hFFFF_7FFF;    // Far from the reset image, request bit clear
        game_pause = 1'b1;
        coin = 2'b11;
        pixel = '0;
        lfsr = 32'd10;
        value_errors = 0;
        timeout_errors = 0;
        wbank_m = 1'b0;
        hs_prev = 1'b0;
        vs_prev = 1'b0;
        phase_m = 1'b1;
        x2_pending = 1'b0;
        widx = 0;
        ridx = 0;
        hpos = 0;
        vpos = 0;
        gap = 0;
        cyc = 0;
        frames = 0;
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < HLEN; i++) begin
                line_v[b][i] = 1'b0;
            end
        end
        repeat (3) @(posedge clk_sys);
        #1;
        check_cfg("cfg_reset", {1'b1, LEVEL_NORMAL, 2'b00, 1'b1, 1'b1}, cfg);
        check_bit("coin_any_reset", 1'b0, coin_any);
        check_bit("game_reset_reset", 1'b1, game_reset);
        reset = 1'b0;
        while (frames < FRAMES && cyc < TIMEOUT) begin
            @(posedge clk_sys);
            #1;
            cyc++;
            gap++;
            // Inputs held over the last edge
            check_cfg("cfg", dip_rule(status, game_pause), cfg);
            check_bit("coin_any", |coin, coin_any);
            check_bit("game_reset", status[15], game_reset);
            if (x2_pending) begin
                check_pixel("x2_pixel", exp_px, {vga_r[5:3], vga_g[5:3], vga_b[5:4]});
                check_chan("vga_r", widen_3b(exp_px[7:5]), vga_r);
                check_chan("vga_g", widen_3b(exp_px[4:2]), vga_g);
                check_chan("vga_b", widen_2b(exp_px[1:0]), vga_b);
                check_bit("vga_hs", exp_hs, vga_hs);
                x2_pending = 1'b0;
            end
            check_bit("hb", hpos >= HACTIVE, raster.hb);
            check_bit("hs", hpos >= HLEN - 2, raster.hs);
            check_bit("vb", vpos >= VACTIVE, raster.vb);
            check_bit("vs", vpos == VLEN - 1, raster.vs);
            check_bit("vga_vs", vpos == VLEN - 1, vga_vs);
            check_bit("pxl_cen", pxl2_cen & phase_m, pxl_cen);
            if (pxl2_cen) begin
                if (gap != PXL2_DIV) begin
                    $display("FAIL pxl2_spacing expected %0d actual %0d", PXL2_DIV, gap);
                    value_errors++;
                end
                gap = 0;
                phase_m = !phase_m;
            end
            if (raster.hs && !hs_prev) begin    // New input line
                wbank_m = !wbank_m;
                widx = 0;
                ridx = 0;
            end
            if (raster.vs && !vs_prev) begin
                frames++;
            end
            hs_prev = raster.hs;
            vs_prev = raster.vs;
            if (pxl_cen) begin
                take_bits(8, r);
                pixel = r[7:0];
                line_m[wbank_m][widx] = r[7:0];
                line_v[wbank_m][widx] = 1'b1;
                widx = (widx + 1) % HLEN;
                hpos = (hpos + 1) % HLEN;
                if (hpos == 0) begin
                    vpos = (vpos + 1) % VLEN;
                end
            end
            if (pxl2_cen) begin
                exp_px = line_v[!wbank_m][ridx] ? line_m[!wbank_m][ridx] : '0;
                exp_hs = ridx >= HLEN - 2;
                ridx = (ridx + 1) % HLEN;
                x2_pending = 1'b1;    // Output shows up one clock later
            end
            if (cyc % 5 == 0) begin
                take_bits(32, r);
                status = r;
                take_bits(1, r);
                game_pause = r[0];
                take_bits(2, r);
                coin = r[1:0];
            end
        end
        if (frames < FRAMES) begin
            $display("Timeout: only %0d of %0d frames seen in %0d cycles", frames, FRAMES, cyc);
            timeout_errors++;
        end
        $display("Errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
hw/arcade_pkg.sv
hw/dip_mapper.sv
hw/video_timing.sv
hw/scan_doubler.sv
hw/arcade_frame.sv
tests/arcade_frame_properties.sv
tests/tb_arcade_frame.sv

//--- run_sim.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_arcade_frame -Mdir obj_dir \
    -f src.f \
    && ./obj_dir/Vtb_arcade_frame > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0
